// ==== chess_pkg.sv ====
package chess_pkg;

	// a square holds {colour, kind}
	localparam logic white = 1'b0;
	localparam logic black = 1'b1;

	localparam logic [2:0] piece_empty  = 3'd0;
	localparam logic [2:0] piece_pawn   = 3'd1;
	localparam logic [2:0] piece_knight = 3'd2;
	localparam logic [2:0] piece_bishop = 3'd3;
	localparam logic [2:0] piece_rook   = 3'd4;
	localparam logic [2:0] piece_queen  = 3'd5;
	localparam logic [2:0] piece_king   = 3'd6;

	typedef logic [3:0]   sq_code_t;
	typedef logic [255:0] board_t;    // nibble index = rank*8 + file, a1 lowest
	typedef logic [2:0]   coord_t;    // one file or one rank, 0 based
	typedef logic [5:0]   sq_t;       // {file, rank}

	typedef logic [6:0]   move_flags_t;
	typedef logic [18:0]  move_t;     // {flags, from, to}
	typedef logic [159:0] batch_t;    // 8 zero bits, then slots 7 down to 0

	localparam int move_w      = $bits(move_t);
	localparam int batch_slots = 8;

	// bit positions inside move_flags_t
	localparam int flag_invalid     = 6;
	localparam int flag_promote     = 5;
	localparam int flag_pawn_move   = 4;
	localparam int flag_pawn_double = 3;
	localparam int flag_en_passant  = 2;
	localparam int flag_castle      = 1;
	localparam int flag_capture     = 0;

	localparam move_flags_t flags_castle = move_flags_t'(1 << flag_castle);
	localparam move_flags_t flags_en_passant =
		move_flags_t'((1 << flag_pawn_move) | (1 << flag_en_passant) | (1 << flag_capture));

	localparam move_t invalid_move = {move_flags_t'(1 << flag_invalid), 12'd0};

	// every slot unused
	localparam batch_t empty_batch = {8'd0, {batch_slots{invalid_move}}};

	typedef enum logic [1:0] {
		seq_reset,
		seq_castle,
		seq_en_passant,
		seq_done
	} seq_state_t;

	function automatic sq_code_t board_sq(input board_t b, input coord_t file,
		input coord_t rank);
		return b[{rank, file, 2'b00} +: 4];
	endfunction

	function automatic sq_t make_sq(input coord_t file, input coord_t rank);
		return {file, rank};
	endfunction

	function automatic move_t make_move(input move_flags_t flags, input sq_t from,
		input sq_t to);
		return {flags, from, to};
	endfunction

endpackage

// ==== castle_check.sv ====
`timescale 1ns/100ps

module castle_check
	import chess_pkg::*;
(
	input  board_t bstate,
	input  logic   lcas_flag,
	input  logic   rcas_flag,
	output batch_t castle_batch,
	output logic   castle_any
);

	localparam sq_code_t white_king = {white, piece_king};
	localparam sq_code_t white_rook = {white, piece_rook};
	localparam coord_t   rank_1     = 3'd0;
	localparam sq_t      sq_e1      = 6'o40;
	localparam sq_t      sq_g1      = 6'o60;
	localparam sq_t      sq_c1      = 6'o20;

	logic king_home;
	logic cas_k;
	logic cas_q;

	// colour bit of an empty square is ignored
	function automatic logic vacant(input board_t b, input coord_t file);
		sq_code_t code;
		code = board_sq(b, file, rank_1);
		return code[2:0] == piece_empty;
	endfunction

	assign king_home = board_sq(bstate, 3'd4, rank_1) == white_king;

	// no attack test on the king path
	assign cas_k = rcas_flag && king_home && vacant(bstate, 3'd5) && vacant(bstate, 3'd6)
		&& (board_sq(bstate, 3'd7, rank_1) == white_rook);
	assign cas_q = lcas_flag && king_home && vacant(bstate, 3'd1) && vacant(bstate, 3'd2)
		&& vacant(bstate, 3'd3) && (board_sq(bstate, 3'd0, rank_1) == white_rook);

	assign castle_any = cas_k || cas_q;

	always_comb begin
		castle_batch = empty_batch;
		if (cas_k)
			castle_batch[7*move_w +: move_w] = make_move(flags_castle, sq_e1, sq_g1); // O-O
		if (cas_q)
			castle_batch[6*move_w +: move_w] = make_move(flags_castle, sq_e1, sq_c1); // O-O-O
	end

endmodule

// ==== en_passant_gen.sv ====
`timescale 1ns/100ps

module en_passant_gen
	import chess_pkg::*;
(
	input  board_t     bstate,
	input  logic [7:0] enp_flags,   // bit 0 is the a-file
	output batch_t     ep_batch,
	output logic       ep_any
);

	localparam sq_code_t white_pawn = {white, piece_pawn};
	localparam coord_t   rank_5     = 3'd4;
	localparam coord_t   rank_6     = 3'd5;
	localparam int       slot_left  = 7;
	localparam int       slot_right = 6;

	coord_t ep_file;
	logic   ep_valid;
	coord_t left_file;
	coord_t right_file;
	sq_t    target;
	logic   left_ok;
	logic   right_ok;

	// lowest set flag wins, so scan from the top down
	always_comb begin
		ep_file = 3'd0;
		ep_valid = 1'b0;
		for (int i = 7; i >= 0; i--) begin
			if (enp_flags[i]) begin
				ep_file = coord_t'(i);
				ep_valid = 1'b1;
			end
		end
	end

	assign left_file  = ep_file - 3'd1;
	assign right_file = ep_file + 3'd1;
	assign target     = make_sq(ep_file, rank_6);

	// edge files have a single neighbour
	assign left_ok = ep_valid && (ep_file != 3'd0)
		&& (board_sq(bstate, left_file, rank_5) == white_pawn);
	assign right_ok = ep_valid && (ep_file != 3'd7)
		&& (board_sq(bstate, right_file, rank_5) == white_pawn);

	assign ep_any = left_ok || right_ok;

	always_comb begin
		ep_batch = empty_batch;
		if (left_ok) begin
			ep_batch[slot_left*move_w +: move_w] =
				make_move(flags_en_passant, make_sq(left_file, rank_5), target);
		end
		if (right_ok) begin
			ep_batch[slot_right*move_w +: move_w] =
				make_move(flags_en_passant, make_sq(right_file, rank_5), target);
		end
	end

endmodule

// ==== move_sequencer.sv ====
`timescale 1ns/100ps

module move_sequencer
	import chess_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  batch_t castle_batch,
	input  batch_t ep_batch,
	input  logic   castle_any,
	input  logic   ep_any,
	input  logic   full,
	output logic   wr_en,
	output batch_t wr_batch,
	output logic   done
);

	seq_state_t state;
	seq_state_t state_next;
	logic       need_write;   // current state has a batch to push

	always_ff @(posedge clk) begin
		if (reset)
			state <= seq_reset;
		else
			state <= state_next;
	end

	always_comb begin
		case (state)
			seq_castle:     need_write = castle_any;
			seq_en_passant: need_write = ep_any;
			default:        need_write = 1'b0;
		endcase
	end

	// a queued write waits out a full FIFO
	assign wr_en = need_write && !full;

	assign wr_batch = (state == seq_en_passant) ? ep_batch : castle_batch;

	always_comb begin
		state_next = state;
		case (state)
			seq_reset: begin
				state_next = seq_castle;
			end
			seq_castle: begin
				if (!need_write || !full)
					state_next = seq_en_passant;
			end
			seq_en_passant: begin
				if (!need_write || !full)
					state_next = seq_done;
			end
			seq_done: begin
				state_next = seq_done;   // held until reset
			end
			default: begin
				state_next = seq_reset;
			end
		endcase
	end

	assign done = state == seq_done;

endmodule

// ==== move_fifo.sv ====
`timescale 1ns/100ps

module move_fifo
	import chess_pkg::*;
#(
	parameter int fifo_depth = 4
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   wr_en,
	input  batch_t wr_batch,
	input  logic   rden,
	output batch_t fifo_out,
	output logic   fifo_empty,
	output logic   full
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	batch_t           mem [fifo_depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic             do_wr;
	logic             do_rd;

	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full       = count == cnt_w'(fifo_depth);
	assign fifo_empty = count == '0;

	assign do_wr = wr_en && !full;
	assign do_rd = rden && !fifo_empty;   // pop on empty is dropped

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_rd)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_batch;
	end

	// show-ahead, head entry is always on the output
	assign fifo_out = mem[rd_ptr];

endmodule

// ==== move_gen_top.sv ====
`timescale 1ns/100ps

module move_gen_top
	import chess_pkg::*;
#(
	parameter int fifo_depth = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  board_t     bstate,
	input  logic       lcas_flag,
	input  logic       rcas_flag,
	input  logic       rden,
	input  logic [7:0] enp_flags,
	output logic       done,
	output logic       fifo_empty,
	output batch_t     fifo_out
);

	batch_t castle_batch;
	logic   castle_any;
	batch_t ep_batch;
	logic   ep_any;
	logic   wr_en;
	batch_t wr_batch;
	logic   full;

	castle_check u_castle (
		.bstate       (bstate),
		.lcas_flag    (lcas_flag),
		.rcas_flag    (rcas_flag),
		.castle_batch (castle_batch),
		.castle_any   (castle_any)
	);

	en_passant_gen u_en_passant (
		.bstate    (bstate),
		.enp_flags (enp_flags),
		.ep_batch  (ep_batch),
		.ep_any    (ep_any)
	);

	move_sequencer u_seq (
		.clk          (clk),
		.reset        (reset),
		.castle_batch (castle_batch),
		.ep_batch     (ep_batch),
		.castle_any   (castle_any),
		.ep_any       (ep_any),
		.full         (full),
		.wr_en        (wr_en),
		.wr_batch     (wr_batch),
		.done         (done)
	);

	move_fifo #(
		.fifo_depth (fifo_depth)
	) u_fifo (
		.clk        (clk),
		.reset      (reset),
		.wr_en      (wr_en),
		.wr_batch   (wr_batch),
		.rden       (rden),
		.fifo_out   (fifo_out),
		.fifo_empty (fifo_empty),
		.full       (full)
	);

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int half_period  = 2;    // 4 ns clock
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// power-on reset, let go on a falling edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== tb_move_gen.sv ====
`timescale 1ns/100ps

module tb_move_gen
	import chess_pkg::*;
();

	localparam int reset_cycles = 10;
	localparam int done_limit   = 20;   // done is due 3 edges after release
	localparam int por_limit    = 40;

	logic       clk;
	logic       por_reset;
	logic       case_reset;
	logic       reset;
	board_t     bstate;
	logic       lcas_flag;
	logic       rcas_flag;
	logic       rden;
	logic [7:0] enp_flags;
	logic       done;
	logic       fifo_empty;
	batch_t     fifo_out;

	logic [15:0] lfsr;
	int          cases_run;
	int          last_count;
	batch_t      last_first;

	tb_clock clock_gen (
		.clk   (clk),
		.reset (por_reset)
	);

	assign reset = por_reset || case_reset;

	move_gen_top #(
		.fifo_depth (4)
	) UUT (
		.clk        (clk),
		.reset      (reset),
		.bstate     (bstate),
		.lcas_flag  (lcas_flag),
		.rcas_flag  (rcas_flag),
		.rden       (rden),
		.enp_flags  (enp_flags),
		.done       (done),
		.fifo_empty (fifo_empty),
		.fifo_out   (fifo_out)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "testbench stopped on the first error");
	endtask

	task automatic check_value(input batch_t got, input batch_t expected, input string what);
		if (got !== expected) begin
			stop_on_error($sformatf("Fail at %0t, case %0d: %s, got %h, expected %h",
				$time, cases_run, what, got, expected));
		end
	endtask

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hb400;
		return s >> 1;
	endfunction

	task automatic random_bit(output logic b);
		b = lfsr[0];
		lfsr = next_lfsr(lfsr);
	endtask

	// 0 to 3 idle cycles between pops
	task automatic idle_gap();
		logic hi;
		logic lo;
		random_bit(hi);
		random_bit(lo);
		repeat ({hi, lo}) @(negedge clk);
	endtask

	task automatic wait_por();
		int n;
		n = 0;
		@(posedge clk);
		while (por_reset) begin
			if (n == por_limit) begin
				stop_on_error("power-on reset was never released");
			end else begin
				@(posedge clk);
				n++;
			end
		end
	endtask

	task automatic wait_done(output int cycles);
		cycles = 0;
		while (!done) begin
			if (cycles == done_limit) begin
				stop_on_error($sformatf("case %0d: done never rose after reset", cases_run));
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	task automatic pulse_reset();
		case_reset = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		case_reset = 1'b0;
	endtask

	task automatic run_case(input board_t board, input logic l, input logic r,
		input logic [7:0] enp, input int count, input batch_t first, input batch_t second);
		int     cycles;
		int     i;
		batch_t expected;
		@(negedge clk);
		bstate = board;
		lcas_flag = l;
		rcas_flag = r;
		enp_flags = enp;
		rden = 1'b0;
		pulse_reset();
		check_value(batch_t'(done), '0, "done at reset release");
		check_value(batch_t'(fifo_empty), batch_t'(1), "fifo_empty at reset release");
		wait_done(cycles);
		check_value(batch_t'(cycles), batch_t'(3), "edges from reset release to done");
		for (i = 0; i < count; i++) begin
			idle_gap();
			expected = (i == 0) ? first : second;
			check_value(batch_t'(fifo_empty), '0, $sformatf("fifo_empty before pop %0d", i));
			check_value(fifo_out, expected, $sformatf("batch %0d", i));
			rden = 1'b1;
			@(negedge clk);
			rden = 1'b0;
		end
		check_value(batch_t'(fifo_empty), batch_t'(1), "fifo_empty after the last pop");
	endtask

	// reset hits while batches are still queued
	task automatic reset_mid_case();
		int cycles;
		@(negedge clk);
		pulse_reset();
		wait_done(cycles);
		if (last_count > 0)
			check_value(fifo_out, last_first, "head batch before the mid-case reset");
		case_reset = 1'b1;
		@(negedge clk);
		case_reset = 1'b0;
		check_value(batch_t'(fifo_empty), batch_t'(1), "fifo_empty after mid-case reset");
		check_value(batch_t'(done), '0, "done after mid-case reset");
		wait_done(cycles);
		if (last_count > 0)
			check_value(fifo_out, last_first, "head batch after the queue refills");
	endtask

	initial begin
		int          fd;
		int          n;
		string       line;
		logic [31:0] r8, r7, r6, r5, r4, r3, r2, r1;   // one token per rank, h-file first
		logic [3:0]  l_v;
		logic [3:0]  r_v;
		logic [7:0]  enp_v;
		int          count_v;
		batch_t      b0_v;
		batch_t      b1_v;
		bstate = '0;
		lcas_flag = 1'b0;
		rcas_flag = 1'b0;
		enp_flags = '0;
		rden = 1'b0;
		case_reset = 1'b0;
		lfsr = 16'd41911;
		cases_run = 0;
		last_count = 0;
		last_first = '0;
		wait_por();
		fd = $fopen("move_gen_golden.txt", "r");
		if (fd == 0) begin
			stop_on_error("could not open move_gen_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != 8'h23) begin   // 8'h23 marks a comment
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %d %h %h",
						r8, r7, r6, r5, r4, r3, r2, r1, l_v, r_v, enp_v, count_v, b0_v, b1_v);
					if (n != 14) begin
						stop_on_error($sformatf("malformed line in golden file: %s", line));
					end else begin
						cases_run++;
						run_case({r8, r7, r6, r5, r4, r3, r2, r1}, l_v[0], r_v[0], enp_v,
							count_v, b0_v, b1_v);
						last_count = count_v;
						last_first = b0_v;
					end
				end
			end
			$fclose(fd);
			if (cases_run == 0) begin
				stop_on_error("the golden file holds no cases");
			end else begin
				reset_mid_case();
				$display("STATUS: PASS");
				$finish;
			end
		end
	end

endmodule

// ==== move_gen_golden.txt ====
# columns: ranks 8 down to 1 in hex (h-file digit first), lcas, rcas, enp_flags (hex, bit 0 = a)
# then the batch count and the expected batches in pop order, 0 where a batch is unused
# kingside only, from the right flag
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 40060004 0 1 00 1 0005061000020000400008000100002000040000 0
# queenside only, from the left flag
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 40060004 1 0 00 1 00800000a0420000400008000100002000040000 0
# both wings
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 40060004 1 1 00 1 00050600a0420000400008000100002000040000 0
# knight on g1 blocks kingside
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 42060004 1 1 00 1 00800000a0420000400008000100002000040000 0
# knight on b1 blocks queenside
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 40060024 1 1 00 1 0005061000020000400008000100002000040000 0
# both wings blocked
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 40360024 1 1 00 0 0 0
# both flags cleared
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 40060004 0 0 00 0 0 0
# king on d1
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 40006004 1 1 00 0 0 0
# black rook on h1
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 c0060004 0 1 00 0 0 0
# d-file, pawns on c5 and e5
000e0000 00000000 00000000 00019100 00000000 00000000 00000000 00060000 0 0 08 1 002aa3a564760000400008000100002000040000 0
# a-file edge, pawn on b5
000e0000 00000000 00000000 00000019 00000000 00000000 00000000 00060000 0 0 01 1 008000054c160000400008000100002000040000 0
# h-file edge, pawn on g5
000e0000 00000000 00000000 91000000 00000000 00000000 00000000 00060000 0 0 80 1 002ba7b000020000400008000100002000040000 0
# c and f flags, only c is used
000e0000 00000000 00000000 01910910 00000000 00000000 00000000 00060000 0 0 24 1 002a62b000020000400008000100002000040000 0
# e-file with no adjacent pawn
000e0000 00000000 00000000 10090010 00000000 00000000 00000000 00060000 0 0 10 0 0 0
# kings only
000e0000 00000000 00000000 00000000 00000000 00000000 00000000 00060000 0 0 00 0 0 0
# castling and en passant together
000e0000 00000000 00000000 00019100 00000000 00000000 00000000 40060004 1 1 08 2 00050600a0420000400008000100002000040000 002aa3a564760000400008000100002000040000

// ==== list.f ====
chess_pkg.sv
castle_check.sv
en_passant_gen.sv
move_sequencer.sv
move_fifo.sv
move_gen_top.sv
tb_clock.sv
tb_move_gen.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the move generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f list.f --top-module tb_move_gen -o tb_move_gen \
	&& ./obj_dir/tb_move_gen | tee /dev/stderr | grep -qx "STATUS: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
